// File: nocPkg.sv
package nocPkg;

  localparam int numPorts = 5;
  localparam int dataWidth = 32;
  localparam int lengthWidth = 12; // packet length in flits, head included.

  typedef enum logic [2:0] {
    flitIdle = 3'd0,
    flitHead = 3'd1,
    flitBody = 3'd2,
    flitTail = 3'd3
  } flitType;

  // one-hot with bit 0 for idle and bit p+1 granting port p.
  typedef enum logic [5:0] {
    sIdle   = 6'b000001,
    sGrantL = 6'b000010,
    sGrantN = 6'b000100,
    sGrantE = 6'b001000,
    sGrantW = 6'b010000,
    sGrantS = 6'b100000
  } arbState;

  typedef enum logic [7:0] {
    regCtrl = 8'h00, // port enable mask.
    regCntL = 8'h04,
    regCntN = 8'h08,
    regCntE = 8'h0C,
    regCntW = 8'h10,
    regCntS = 8'h14
  } regAddr;

endpackage

// File: flitQueue.sv
`timescale 1ns/1ps

module flitQueue #(
  parameter int dataWidth = nocPkg::dataWidth,
  parameter int queueDepth = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inValid,
  output logic                 inReady,
  input  nocPkg::flitType      inType,
  input  logic [dataWidth-1:0] inData,
  input  logic                 pop,
  output logic                 notEmpty,
  output nocPkg::flitType      headType,
  output logic [dataWidth-1:0] headData
);
  import nocPkg::*;

  localparam int ptrWidth = $clog2(queueDepth);

  flitType              typeMem [queueDepth];
  logic [dataWidth-1:0] dataMem [queueDepth];
  logic [ptrWidth-1:0]  wrPtr;
  logic [ptrWidth-1:0]  rdPtr;
  logic [ptrWidth:0]    count;
  logic                 push;

  assign notEmpty = (count != '0);
  assign inReady = (count != queueDepth) || pop; // full queue still takes a flit on pop.
  assign push = inValid && inReady;
  assign headType = notEmpty ? typeMem[rdPtr] : flitIdle;
  assign headData = dataMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      typeMem[wrPtr] <= inType;
      dataMem[wrPtr] <= inData;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1; // wraps as depth is a power of two.
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // pop comes from the output stage and must only hit a filled queue.
  assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty);

endmodule

// File: switchArbiter.sv
`timescale 1ns/1ps

module switchArbiter #(
  parameter int dataWidth = nocPkg::dataWidth
) (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic [nocPkg::numPorts-1:0]                          notEmpty,
  input  nocPkg::flitType [nocPkg::numPorts-1:0]               headType,
  input  logic [nocPkg::numPorts-1:0][nocPkg::lengthWidth-1:0] headLength,
  input  logic [nocPkg::numPorts-1:0]                          portEnable,
  input  logic                                                 fire,
  output logic [nocPkg::numPorts-1:0]                          grant
);
  import nocPkg::*;

  arbState                               state;
  arbState                               nextState;
  logic [numPorts-1:0]                   headIsHead;
  logic [numPorts-1:0]                   req;
  logic [numPorts-1:0]                   lastFlit;
  logic [numPorts-1:0]                   startGrant;
  logic [numPorts-1:0][lengthWidth-1:0]  flitCount;
  logic [numPorts-1:0][lengthWidth-1:0]  pktLength;

  if (dataWidth < lengthWidth)
  begin : gLenCheck
    $error("length field does not fit in the flit payload");
  end

  // first requester found from start on, over span ports.
  function automatic arbState pickNext(input int start, input int span,
                                       input logic [numPorts-1:0] r);
    arbState pick;
    int      idx;
    pick = sIdle;
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = (start + k) % numPorts;
      if (r[idx])
        pick = arbState'(6'b000010 << idx);
    end
    return pick;
  endfunction

  assign grant = state[numPorts:1];
  assign startGrant = nextState[numPorts:1] & ~grant;

  always_comb
  begin
    for (int p = 0; p < numPorts; p++)
    begin
      headIsHead[p] = (headType[p] == flitHead);
      req[p] = notEmpty[p] && portEnable[p] && headIsHead[p];
      lastFlit[p] = grant[p] && fire &&
                    (lengthWidth'(flitCount[p] + 1'b1) == pktLength[p]);
    end
  end

  // hold for the whole packet, then rotate starting after the current port.
  always_comb
  begin
    nextState = state;
    if (grant == '0)
      nextState = pickNext(0, numPorts, req);
    else
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        if (lastFlit[p])
          nextState = pickNext(p + 1, numPorts - 1, req);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= sIdle;
      flitCount <= '0;
    end
    else
    begin
      state <= nextState;
      for (int p = 0; p < numPorts; p++)
      begin
        if (startGrant[p] || lastFlit[p])
          flitCount[p] <= '0;
        else if (grant[p] && fire)
          flitCount[p] <= flitCount[p] + 1'b1; // counts flits, not cycles.
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int p = 0; p < numPorts; p++)
    begin
      if (startGrant[p])
        pktLength[p] <= headLength[p]; // head flit is at the queue head here.
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

  // a new grant must find a head flit waiting, not a stray body flit.
  assert property (@(posedge clk) disable iff (rst)
    ((grant & ~$past(grant)) & ~headIsHead) == '0);

endmodule

// File: outputStage.sv
`timescale 1ns/1ps

module outputStage #(
  parameter int dataWidth = nocPkg::dataWidth
) (
  input  logic [nocPkg::numPorts-1:0]                          grant,
  input  logic [nocPkg::numPorts-1:0]                          notEmpty,
  input  nocPkg::flitType [nocPkg::numPorts-1:0]               headType,
  input  logic [nocPkg::numPorts-1:0][dataWidth-1:0]           headData,
  input  logic                                                 outReady,
  output logic                                                 outValid,
  output nocPkg::flitType                                      outType,
  output logic [dataWidth-1:0]                                 outData,
  output logic                                                 fire,
  output logic [nocPkg::numPorts-1:0]                          pop,
  output logic [nocPkg::numPorts-1:0][nocPkg::lengthWidth-1:0] headLength
);
  import nocPkg::*;

  always_comb
  begin
    outValid = 1'b0;
    outType = flitIdle;
    outData = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      if (grant[p])
      begin
        outValid = notEmpty[p];
        outType = headType[p];
        outData = headData[p];
      end
    end
  end

  assign fire = outValid && outReady;
  assign pop = grant & {numPorts{fire}}; // only the granted queue drains.

  // length sits in the low payload bits of a head flit.
  for (genvar p = 0; p < numPorts; p++)
  begin : gLength
    assign headLength[p] = headData[p][lengthWidth-1:0];
  end

endmodule

// File: apbRegs.sv
`timescale 1ns/1ps

module apbRegs (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [7:0]                  paddr,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic [nocPkg::numPorts-1:0] portEnable,
  input  logic [nocPkg::numPorts-1:0] grant,
  input  logic                        fire
);
  import nocPkg::*;

  logic [numPorts-1:0][15:0] flitCnt;
  logic                      access;
  logic                      addrHit;
  logic                      ctrlWrite;

  assign access = psel && penable;
  assign pready = access; // no wait states.
  assign ctrlWrite = access && pwrite && (paddr == regCtrl);
  assign pslverr = access && (!addrHit || (pwrite && (paddr != regCtrl)));

  always_comb
  begin
    prdata = '0;
    addrHit = 1'b1;
    case (paddr)
      regCtrl: prdata = 32'(portEnable);
      regCntL: prdata = 32'(flitCnt[0]);
      regCntN: prdata = 32'(flitCnt[1]);
      regCntE: prdata = 32'(flitCnt[2]);
      regCntW: prdata = 32'(flitCnt[3]);
      regCntS: prdata = 32'(flitCnt[4]);
      default: addrHit = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      portEnable <= '1;
      flitCnt <= '0;
    end
    else
    begin
      if (ctrlWrite)
        portEnable <= pwdata[numPorts-1:0];
      for (int p = 0; p < numPorts; p++)
      begin
        if (fire && grant[p])
          flitCnt[p] <= flitCnt[p] + 1'b1; // wraps.
      end
    end
  end

  // every access phase follows a setup phase.
  assert property (@(posedge clk) disable iff (rst)
    access |-> $past(psel && !penable));

endmodule

// File: routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort #(
  parameter int dataWidth = nocPkg::dataWidth,
  parameter int queueDepth = 4
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [nocPkg::numPorts-1:0]                inValid,
  output logic [nocPkg::numPorts-1:0]                inReady,
  input  nocPkg::flitType [nocPkg::numPorts-1:0]     inType,
  input  logic [nocPkg::numPorts-1:0][dataWidth-1:0] inData,
  output logic                                       outValid,
  input  logic                                       outReady,
  output nocPkg::flitType                            outType,
  output logic [dataWidth-1:0]                       outData,
  input  logic                                       psel,
  input  logic                                       penable,
  input  logic                                       pwrite,
  input  logic [7:0]                                 paddr,
  input  logic [31:0]                                pwdata,
  output logic [31:0]                                prdata,
  output logic                                       pready,
  output logic                                       pslverr
);
  import nocPkg::*;

  logic [numPorts-1:0]                  notEmpty;
  flitType [numPorts-1:0]               headType;
  logic [numPorts-1:0][dataWidth-1:0]   headData;
  logic [numPorts-1:0][lengthWidth-1:0] headLength;
  logic [numPorts-1:0]                  grant;
  logic [numPorts-1:0]                  pop;
  logic [numPorts-1:0]                  portEnable;
  logic                                 fire;

  // one queue per input link in L N E W S order.
  for (genvar p = 0; p < numPorts; p++)
  begin : gQueue
    flitQueue #(
      .dataWidth(dataWidth),
      .queueDepth(queueDepth)
    ) queue (
      .clk(clk),
      .rst(rst),
      .inValid(inValid[p]),
      .inReady(inReady[p]),
      .inType(inType[p]),
      .inData(inData[p]),
      .pop(pop[p]),
      .notEmpty(notEmpty[p]),
      .headType(headType[p]),
      .headData(headData[p])
    );
  end

  switchArbiter #(
    .dataWidth(dataWidth)
  ) arbiter (
    .clk(clk),
    .rst(rst),
    .notEmpty(notEmpty),
    .headType(headType),
    .headLength(headLength),
    .portEnable(portEnable),
    .fire(fire),
    .grant(grant)
  );

  outputStage #(
    .dataWidth(dataWidth)
  ) outStage (
    .grant(grant),
    .notEmpty(notEmpty),
    .headType(headType),
    .headData(headData),
    .outReady(outReady),
    .outValid(outValid),
    .outType(outType),
    .outData(outData),
    .fire(fire),
    .pop(pop),
    .headLength(headLength)
  );

  apbRegs regs (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .portEnable(portEnable),
    .grant(grant),
    .fire(fire)
  );

endmodule

// File: tbRouter.sv
`timescale 1ns/1ps

module tbRouter;
  import nocPkg::*;

  localparam int totalFlits = 39;
  // each flit may wait out a full rotation, plus reset and register traffic.
  localparam int timeoutCycles = totalFlits * numPorts * 8 + 400;

  logic                               clk;
  logic                               rst;
  logic [numPorts-1:0]                inValid;
  logic [numPorts-1:0]                inReady;
  flitType [numPorts-1:0]             inType;
  logic [numPorts-1:0][dataWidth-1:0] inData;
  logic                               outValid;
  logic                               outReady;
  flitType                            outType;
  logic [dataWidth-1:0]               outData;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [7:0]                         paddr;
  logic [31:0]                        pwdata;
  logic [31:0]                        prdata;
  logic                               pready;
  logic                               pslverr;

  logic [dataWidth-1:0] expData [numPorts][$]; // flits still owed, per input port.
  flitType              expType [numPorts][$];
  int                   servedOrder [$]; // source port of each delivered packet.
  int                   wantOrder [$];
  int                   curPort = -1;
  int                   cycles = 0;
  integer               seed = 32'h1205;
  logic                 randomReady = 1'b0;
  string                testName = "reset";

  routerOutputPort #(
    .dataWidth(dataWidth),
    .queueDepth(4)
  ) i_dut (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inReady(inReady),
    .inType(inType),
    .inData(inData),
    .outValid(outValid),
    .outReady(outReady),
    .outType(outType),
    .outData(outData),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Mismatch in %s, %s: expected %0h, actual %0h",
               testName, what, expected, actual);
      failRun("a checked value was wrong");
    end
  endtask

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > timeoutCycles)
      failRun("timeout: the tests did not finish within the cycle limit");
  end

  // a packet's head picks the port and the rest must follow it.
  task automatic takeFlit();
    for (int p = numPorts - 1; p >= 0 && curPort < 0; p--)
    begin
      if (expData[p].size() != 0 && expData[p][0] == outData && outType == flitHead)
      begin
        curPort = p;
        servedOrder.push_back(p);
      end
    end
    if (curPort < 0)
      failRun("unexpected flit on the output link, no packet head matches it");
    if (expData[curPort].size() == 0)
      failRun("flit delivered past the end of a packet");
    checkValue("outType", expType[curPort][0], outType);
    checkValue("outData", expData[curPort][0], outData);
    void'(expData[curPort].pop_front());
    void'(expType[curPort].pop_front());
    if (outType == flitTail)
      curPort = -1;
  endtask

  always @(posedge clk)
  begin
    if (!rst && outValid && outReady)
      takeFlit();
  end

  always @(negedge clk)
  begin
    if (randomReady)
      outReady = ($random(seed) & 1) != 0;
  end

  function automatic bit pending();
    bit busy;
    busy = (curPort >= 0);
    for (int p = 0; p < numPorts; p++)
    begin
      if (expData[p].size() != 0)
        busy = 1'b1;
    end
    return busy;
  endfunction

  task automatic waitDrained();
    while (pending())
      @(negedge clk);
  endtask

  task automatic checkOrder();
    checkValue("packets delivered", wantOrder.size(), servedOrder.size());
    foreach (wantOrder[i])
      checkValue("packet source port", wantOrder[i], servedOrder[i]);
    servedOrder.delete();
  endtask

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    checkValue("pready on write", 1, pready);
    checkValue("pslverr on write", 0, pslverr);
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data,
                         output logic err);
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    checkValue("pready on read", 1, pready);
    data = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic sendPacket(input int port, input int len);
    logic [dataWidth-1:0] word;
    flitType              kind;
    for (int i = 0; i < len; i++)
    begin
      word = $random(seed);
      kind = flitBody;
      if (i == 0)
      begin
        kind = flitHead;
        word[lengthWidth-1:0] = lengthWidth'(len); // length counts the head too.
      end
      else if (i == len - 1)
        kind = flitTail;
      expData[port].push_back(word);
      expType[port].push_back(kind);
      @(negedge clk);
      inValid[port] = 1'b1;
      inType[port] = kind;
      inData[port] = word;
      @(posedge clk);
      while (!inReady[port])
        @(posedge clk);
    end
    @(negedge clk);
    inValid[port] = 1'b0;
  endtask

  task automatic resetTest();
    logic [31:0] data;
    logic        err;
    testName = "reset";
    checkValue("outValid", 0, outValid);
    checkValue("inReady", 5'h1F, inReady);
    apbRead(regCtrl, data, err);
    checkValue("regCtrl", 5'h1F, data);
    checkValue("pslverr on regCtrl read", 0, err);
    for (int p = 0; p < numPorts; p++)
    begin
      apbRead(8'(regCntL) + 8'(4 * p), data, err);
      checkValue("flit counter", 0, data);
    end
    apbRead(8'h40, data, err);
    checkValue("pslverr on unmapped read", 1, err);
  endtask

  task automatic singlePacketTest();
    logic [31:0] data;
    logic        err;
    testName = "singlePacket";
    sendPacket(1, 5);
    waitDrained();
    wantOrder = '{1};
    checkOrder();
    apbRead(regCntN, data, err);
    checkValue("regCntN", 5, data);
  endtask

  task automatic rotationTest();
    testName = "rotation";
    fork
      sendPacket(0, 4);
      sendPacket(2, 4);
      sendPacket(4, 4);
      begin
        while (curPort != 2)
          @(negedge clk);
        sendPacket(0, 3); // S is ahead of L once E is done.
      end
    join
    waitDrained();
    wantOrder = '{0, 2, 4, 0};
    checkOrder();
  endtask

  task automatic backPressureTest();
    logic [31:0] data;
    logic        err;
    testName = "backPressure";
    @(negedge clk);
    outReady = 1'b0;
    fork
      sendPacket(1, 6);
      sendPacket(3, 6);
      begin
        while (inReady[1])
          @(negedge clk);
        // both queues full, N holds the grant with its head still waiting.
        checkValue("inReady on W while stalled", 0, inReady[3]);
        checkValue("outValid while stalled", 1, outValid);
        checkValue("outType while stalled", flitHead, outType);
        checkValue("outData while stalled", expData[1][0], outData);
        randomReady = 1'b1;
      end
    join
    waitDrained();
    randomReady = 1'b0;
    outReady = 1'b1;
    wantOrder = '{1, 3};
    checkOrder();
    apbRead(regCntN, data, err);
    checkValue("regCntN", 11, data);
    apbRead(regCntW, data, err);
    checkValue("regCntW", 6, data);
  endtask

  task automatic enableMaskTest();
    logic [31:0] data;
    logic        err;
    testName = "enableMask";
    apbWrite(regCtrl, 32'h17); // west off.
    fork
      sendPacket(3, 4);
      sendPacket(1, 3);
    join
    while (expData[1].size() != 0 || curPort >= 0)
      @(negedge clk);
    repeat (10) @(negedge clk);
    checkValue("west flits still queued", 4, expData[3].size());
    checkValue("outValid with west off", 0, outValid);
    apbWrite(regCtrl, 32'h1F);
    waitDrained();
    wantOrder = '{1, 3};
    checkOrder();
    apbRead(regCntW, data, err);
    checkValue("regCntW", 10, data);
  endtask

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    inData = '0;
    for (int p = 0; p < numPorts; p++)
      inType[p] = flitIdle;
    outReady = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    resetTest();
    singlePacketTest();
    rotationTest();
    backPressureTest();
    enableMaskTest();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: project.f
nocPkg.sv
flitQueue.sv
switchArbiter.sv
outputStage.sv
apbRegs.sv
routerOutputPort.sv
tbRouter.sv
